// File: rtl/dmem_pkg.sv
package dmem_pkg;

    localparam int word_w = 32;
    localparam int line_words = 4;
    localparam int offset_w = 4;
    localparam int len_w = 8;

    // one line moves as a single burst
    localparam logic [len_w-1:0] burst_len = len_w'(line_words - 1);

    localparam logic op_load = 1'b0;
    localparam logic op_store = 1'b1;

    // cacop_code[2:0] picks the cache, [4:3] the operation
    localparam logic [4:0] cacop_init = 5'b00001;
    localparam logic [4:0] cacop_idx_wb = 5'b01001;

    localparam logic [5:0] ecode_ale = 6'h09;
    localparam logic [5:0] ecode_bus = 6'h0a;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: rtl/axi_rd_if.sv
interface axi_rd_if (
    input logic clk
);
    logic ar_valid;
    logic ar_ready;
    logic [dmem_pkg::word_w-1:0] ar_addr;
    logic [dmem_pkg::len_w-1:0] ar_len;
    logic r_valid;
    logic r_ready;
    logic [dmem_pkg::word_w-1:0] r_data;
    logic r_last;
    logic [1:0] r_resp;

    modport master (
        output ar_valid, ar_addr, ar_len, r_ready,
        input ar_ready, r_valid, r_data, r_last, r_resp
    );
    modport slave (
        input ar_valid, ar_addr, ar_len, r_ready,
        output ar_ready, r_valid, r_data, r_last, r_resp
    );

    // a pending read request holds until it is taken
    ap_ar_hold: assert property (@(posedge clk)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len));

endinterface

// File: rtl/axi_wr_if.sv
interface axi_wr_if (
    input logic clk
);
    logic aw_valid;
    logic aw_ready;
    logic [dmem_pkg::word_w-1:0] aw_addr;
    logic [dmem_pkg::len_w-1:0] aw_len;
    logic w_valid;
    logic w_ready;
    logic [dmem_pkg::word_w-1:0] w_data;
    logic [3:0] w_strb;
    logic w_last;
    logic b_valid;
    logic b_ready;
    logic [1:0] b_resp;

    modport master (
        output aw_valid, aw_addr, aw_len, w_valid, w_data, w_strb, w_last, b_ready,
        input aw_ready, w_ready, b_valid, b_resp
    );
    modport slave (
        input aw_valid, aw_addr, aw_len, w_valid, w_data, w_strb, w_last, b_ready,
        output aw_ready, w_ready, b_valid, b_resp
    );

    // a pending write request holds until it is taken
    ap_aw_hold: assert property (@(posedge clk)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len));

endinterface

// File: rtl/dcache.sv
module dcache #(
    parameter int index_w = 6
) (
    input  logic clk,
    input  logic arst_n,
    input  logic valid,
    input  logic op,
    input  logic [dmem_pkg::word_w-1:0] addr,
    input  logic [dmem_pkg::word_w-1:0] w_data_cpu,
    input  logic [3:0] write_type,
    input  logic cacop_en,
    input  logic [4:0] cacop_code,
    output logic data_valid,
    output logic [dmem_pkg::word_w-1:0] r_data_cpu,
    output logic [6:0] exp,
    axi_rd_if.master rd,
    axi_wr_if.master wr
);

    localparam int lines = 2 ** index_w;
    localparam int word_bits = $clog2(dmem_pkg::line_words);
    localparam int tag_w = dmem_pkg::word_w - index_w - dmem_pkg::offset_w;

    typedef enum logic [2:0] {
        s_idle, s_lookup, s_wb_aw, s_wb_w, s_wb_b, s_rf_ar, s_rf_r
    } state_t;

    state_t state;
    state_t state_next;

    // lookup stage request
    logic req_op;
    logic [dmem_pkg::word_w-1:0] req_addr;
    logic [dmem_pkg::word_w-1:0] req_wdata;
    logic [3:0] req_strb;
    logic req_cacop;
    logic [4:0] req_code;

    logic [tag_w-1:0] tag_arr [lines];
    logic [dmem_pkg::word_w-1:0] data_arr [lines * dmem_pkg::line_words];
    logic [lines-1:0] line_valid;
    logic [lines-1:0] line_dirty;

    logic [word_bits-1:0] beat;
    logic bus_err;

    logic [tag_w-1:0] req_tag;
    logic [index_w-1:0] req_idx;
    logic [word_bits-1:0] req_word;
    logic hit;
    logic victim_dirty;
    logic misaligned;
    logic [dmem_pkg::word_w-1:0] hit_word;
    logic [dmem_pkg::word_w-1:0] merged_word;

    logic done;
    logic [6:0] done_exp;
    logic store_hit;
    logic inval;
    logic wb_beat;
    logic rf_beat;
    logic err_now;

    assign req_tag = req_addr[dmem_pkg::word_w-1 -: tag_w];
    assign req_idx = req_addr[dmem_pkg::offset_w +: index_w];
    assign req_word = req_addr[2 +: word_bits];
    assign hit = line_valid[req_idx] && (tag_arr[req_idx] == req_tag);
    assign victim_dirty = line_valid[req_idx] && line_dirty[req_idx];
    assign misaligned = req_addr[1:0] != 2'b00;
    assign hit_word = data_arr[{req_idx, req_word}];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = req_strb[b] ? req_wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    // refill reads the requested line, writeback sends the resident one
    assign rd.ar_valid = state == s_rf_ar;
    assign rd.ar_addr = {req_tag, req_idx, {dmem_pkg::offset_w{1'b0}}};
    assign rd.ar_len = dmem_pkg::burst_len;
    assign rd.r_ready = state == s_rf_r;

    assign wr.aw_valid = state == s_wb_aw;
    assign wr.aw_addr = {tag_arr[req_idx], req_idx, {dmem_pkg::offset_w{1'b0}}};
    assign wr.aw_len = dmem_pkg::burst_len;
    assign wr.w_valid = state == s_wb_w;
    assign wr.w_data = data_arr[{req_idx, beat}];
    assign wr.w_strb = 4'hf;
    assign wr.w_last = beat == word_bits'(dmem_pkg::line_words - 1);
    assign wr.b_ready = state == s_wb_b;

    assign wb_beat = wr.w_valid && wr.w_ready;
    assign rf_beat = rd.r_valid && rd.r_ready;
    assign err_now = bus_err
        || (wr.b_valid && wr.b_ready && wr.b_resp != dmem_pkg::resp_okay)
        || (rf_beat && rd.r_resp != dmem_pkg::resp_okay);

    always_comb begin
        state_next = state;
        done = 1'b0;
        done_exp = '0;
        store_hit = 1'b0;
        inval = 1'b0;
        case (state)
            s_idle: begin
                if (valid) begin
                    state_next = s_lookup;
                end
            end
            s_lookup: begin
                if (req_cacop) begin
                    if (req_code == dmem_pkg::cacop_idx_wb && victim_dirty) begin
                        state_next = s_wb_aw;
                    end else begin
                        // unknown codes finish without touching the line
                        inval = req_code == dmem_pkg::cacop_init
                            || req_code == dmem_pkg::cacop_idx_wb;
                        done = 1'b1;
                    end
                end else if (misaligned) begin
                    done = 1'b1;
                    done_exp = {1'b1, dmem_pkg::ecode_ale};
                end else if (hit) begin
                    done = 1'b1;
                    store_hit = req_op == dmem_pkg::op_store;
                end else if (victim_dirty) begin
                    state_next = s_wb_aw;
                end else begin
                    state_next = s_rf_ar;
                end
            end
            s_wb_aw: begin
                if (wr.aw_ready) begin
                    state_next = s_wb_w;
                end
            end
            s_wb_w: begin
                if (wb_beat && wr.w_last) begin
                    state_next = s_wb_b;
                end
            end
            s_wb_b: begin
                if (wr.b_valid) begin
                    inval = 1'b1;
                    if (req_cacop) begin
                        done = 1'b1;
                    end else begin
                        state_next = s_rf_ar;
                    end
                end
            end
            s_rf_ar: begin
                if (rd.ar_ready) begin
                    state_next = s_rf_r;
                end
            end
            s_rf_r: begin
                if (rf_beat && rd.r_last) begin
                    // a good refill replays the access as a hit
                    if (err_now) begin
                        done = 1'b1;
                    end else begin
                        state_next = s_lookup;
                    end
                end
            end
            default: begin
                state_next = s_idle;
            end
        endcase
        if (done) begin
            state_next = s_idle;
            if (err_now) begin
                done_exp = {1'b1, dmem_pkg::ecode_bus};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            data_valid <= 1'b0;
            exp <= '0;
            line_valid <= '0;
            line_dirty <= '0;
            beat <= '0;
            bus_err <= 1'b0;
        end else begin
            state <= state_next;
            data_valid <= done;
            exp <= done_exp;
            bus_err <= (state == s_idle) ? 1'b0 : err_now;
            if (state == s_idle) begin
                beat <= '0;
            end else if (wb_beat || rf_beat) begin
                beat <= beat + 1'b1;
            end
            if (store_hit) begin
                line_dirty[req_idx] <= 1'b1;
            end
            if (inval) begin
                line_valid[req_idx] <= 1'b0;
                line_dirty[req_idx] <= 1'b0;
            end
            if (rf_beat && rd.r_last) begin
                line_valid[req_idx] <= !err_now;
                line_dirty[req_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && valid) begin
            req_op <= op;
            req_addr <= addr;
            req_wdata <= w_data_cpu;
            req_strb <= write_type;
            req_cacop <= cacop_en;
            req_code <= cacop_code;
        end
        if (store_hit) begin
            data_arr[{req_idx, req_word}] <= merged_word;
        end
        if (rf_beat) begin
            data_arr[{req_idx, beat}] <= rd.r_data;
        end
        if (rf_beat && rd.r_last) begin
            tag_arr[req_idx] <= req_tag;
        end
        if (done && req_op == dmem_pkg::op_load) begin
            r_data_cpu <= hit_word;
        end
    end

    ap_dv_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid |=> !data_valid);

    ap_ar_aw_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(rd.ar_valid && wr.aw_valid));

    // the CPU keeps a single request in flight
    ap_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> state == s_idle);

endmodule

// File: rtl/axi_memory.sv
module axi_memory #(
    parameter int mem_words = 1024,
    parameter int mem_latency = 3
) (
    input logic clk,
    input logic arst_n,
    axi_rd_if.slave rd,
    axi_wr_if.slave wr
);

    localparam int mem_aw = $clog2(mem_words);
    localparam int lat_w = $clog2(mem_latency + 1);
    localparam int waddr_w = dmem_pkg::word_w - 2;
    localparam logic [waddr_w-1:0] mem_limit = waddr_w'(mem_words);

    typedef enum logic [1:0] {r_idle, r_wait, r_send} rd_state_t;
    typedef enum logic [1:0] {w_idle, w_data, w_resp} wr_state_t;

    logic [dmem_pkg::word_w-1:0] mem [mem_words];

    rd_state_t rd_state;
    logic [lat_w-1:0] lat_cnt;
    logic [dmem_pkg::len_w-1:0] rd_cnt;
    logic [dmem_pkg::len_w-1:0] rd_len;
    logic [waddr_w-1:0] rd_word;
    logic [waddr_w-1:0] rd_base;
    logic rd_in_range;

    wr_state_t wr_state;
    logic [dmem_pkg::len_w-1:0] wr_cnt;
    logic [dmem_pkg::len_w-1:0] wr_len;
    logic [waddr_w-1:0] wr_word;
    logic wr_in_range;
    logic wr_err;

    // every word starts out holding its own byte address
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = i * 4;
        end
    end

    assign rd_in_range = rd_word < mem_limit;
    assign wr_in_range = wr_word < mem_limit;

    assign rd.ar_ready = rd_state == r_idle;
    assign rd.r_valid = rd_state == r_send;
    assign rd.r_data = rd_in_range ? mem[rd_word[mem_aw-1:0]] : '0;
    assign rd.r_resp = rd_in_range ? dmem_pkg::resp_okay : dmem_pkg::resp_slverr;
    assign rd.r_last = rd_cnt == rd_len;

    assign wr.aw_ready = wr_state == w_idle;
    assign wr.w_ready = wr_state == w_data;
    assign wr.b_valid = wr_state == w_resp;
    assign wr.b_resp = wr_err ? dmem_pkg::resp_slverr : dmem_pkg::resp_okay;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_state <= r_idle;
            lat_cnt <= '0;
            rd_cnt <= '0;
            wr_state <= w_idle;
            wr_cnt <= '0;
            wr_err <= 1'b0;
        end else begin
            case (rd_state)
                r_idle: begin
                    if (rd.ar_valid) begin
                        rd_state <= r_wait;
                        lat_cnt <= lat_w'(mem_latency - 1);
                        rd_cnt <= '0;
                    end
                end
                r_wait: begin
                    if (lat_cnt == '0) begin
                        rd_state <= r_send;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                r_send: begin
                    if (rd.r_ready) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (rd.r_last) begin
                            rd_state <= r_idle;
                        end
                    end
                end
                default: begin
                    rd_state <= r_idle;
                end
            endcase

            case (wr_state)
                w_idle: begin
                    if (wr.aw_valid) begin
                        wr_state <= w_data;
                        wr_cnt <= '0;
                        wr_err <= 1'b0;
                    end
                end
                w_data: begin
                    if (wr.w_valid) begin
                        wr_cnt <= wr_cnt + 1'b1;
                        if (!wr_in_range) begin
                            wr_err <= 1'b1;
                        end
                        // burst ends on the count taken from aw_len
                        if (wr_cnt == wr_len) begin
                            wr_state <= w_resp;
                        end
                    end
                end
                w_resp: begin
                    if (wr.b_ready) begin
                        wr_state <= w_idle;
                    end
                end
                default: begin
                    wr_state <= w_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd.ar_valid && rd.ar_ready) begin
            rd_word <= rd.ar_addr[dmem_pkg::word_w-1:2];
            rd_base <= rd.ar_addr[dmem_pkg::word_w-1:2];
            rd_len <= rd.ar_len;
        end else if (rd.r_valid && rd.r_ready) begin
            rd_word <= rd_word + 1'b1;
        end
        if (wr.aw_valid && wr.aw_ready) begin
            wr_word <= wr.aw_addr[dmem_pkg::word_w-1:2];
            wr_len <= wr.aw_len;
        end else if (wr.w_valid && wr.w_ready) begin
            wr_word <= wr_word + 1'b1;
        end
    end

    // out of range beats are dropped
    always @(posedge clk) begin
        if (wr.w_valid && wr.w_ready && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.w_strb[b]) begin
                    mem[wr_word[mem_aw-1:0]][8*b +: 8] <= wr.w_data[8*b +: 8];
                end
            end
        end
    end

    // the last beat is the one whose word sits ar_len words past the burst start
    ap_r_last: assert property (@(posedge clk) disable iff (!arst_n)
        rd.r_valid |-> rd.r_last == ((rd_word - rd_base) == waddr_w'(rd_len)));

    ap_w_last: assert property (@(posedge clk) disable iff (!arst_n)
        wr.w_valid && wr.w_ready |-> wr.w_last == (wr_cnt == wr_len));

endmodule

// File: rtl/data_mem.sv
module data_mem #(
    parameter int index_w = 6,
    parameter int mem_words = 1024,
    parameter int mem_latency = 3
) (
    input  logic clk,
    input  logic arst_n,
    input  logic valid,
    input  logic op,
    input  logic [dmem_pkg::word_w-1:0] addr,
    input  logic [dmem_pkg::word_w-1:0] w_data_cpu,
    input  logic [3:0] write_type,
    input  logic cacop_en,
    input  logic [4:0] cacop_code,
    output logic data_valid,
    output logic [dmem_pkg::word_w-1:0] r_data_cpu,
    output logic [6:0] exp
);

    axi_rd_if rd_bus (.clk(clk));
    axi_wr_if wr_bus (.clk(clk));

    dcache #(
        .index_w (index_w)
    ) cache0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (valid),
        .op         (op),
        .addr       (addr),
        .w_data_cpu (w_data_cpu),
        .write_type (write_type),
        .cacop_en   (cacop_en),
        .cacop_code (cacop_code),
        .data_valid (data_valid),
        .r_data_cpu (r_data_cpu),
        .exp        (exp),
        .rd         (rd_bus.master),
        .wr         (wr_bus.master)
    );

    axi_memory #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) mem0 (
        .clk    (clk),
        .arst_n (arst_n),
        .rd     (rd_bus.slave),
        .wr     (wr_bus.slave)
    );

endmodule

// File: dv/tb_data_mem.sv
module tb_data_mem;

    localparam int index_w = 6;
    localparam int mem_words = 1024;
    localparam int lines = 2 ** index_w;
    localparam int tag_w = dmem_pkg::word_w - index_w - dmem_pkg::offset_w;
    localparam int mem_aw = $clog2(mem_words);
    localparam int n_random = 300;
    // about 400 requests at no more than 50 cycles each
    localparam int cycle_limit = (n_random + 100) * 50;
    localparam logic [6:0] exp_ale = {1'b1, dmem_pkg::ecode_ale};
    localparam logic [6:0] exp_bus = {1'b1, dmem_pkg::ecode_bus};

    logic clk;
    logic arst_n;
    logic valid;
    logic op;
    logic [31:0] addr;
    logic [31:0] w_data_cpu;
    logic [3:0] write_type;
    logic cacop_en;
    logic [4:0] cacop_code;
    logic data_valid;
    logic [31:0] r_data_cpu;
    logic [6:0] exp;

    // reference models of memory and cache
    logic [31:0] mem_m [mem_words];
    logic [31:0] line_m [lines * 4];
    logic [tag_w-1:0] tag_m [lines];
    logic [lines-1:0] val_m;
    logic [lines-1:0] dirty_m;

    logic [31:0] lfsr;
    int cycles = 0;
    logic started;
    logic fast;
    logic fast_due;
    logic chk_data;
    logic [31:0] want_data;
    logic [6:0] want_exp;

    data_mem dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid      (valid),
        .op         (op),
        .addr       (addr),
        .w_data_cpu (w_data_cpu),
        .write_type (write_type),
        .cacop_en   (cacop_en),
        .cacop_code (cacop_code),
        .data_valid (data_valid),
        .r_data_cpu (r_data_cpu),
        .exp        (exp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_run("run did not finish within the cycle limit");
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return v;
    endfunction

    task automatic write_back(input logic [index_w-1:0] idx);
        logic [dmem_pkg::word_w-3:0] waddr;
        for (int i = 0; i < 4; i++) begin
            waddr = {tag_m[idx], idx, 2'(i)};
            mem_m[waddr[mem_aw-1:0]] = line_m[{idx, 2'(i)}];
        end
    endtask

    task automatic refill(input logic [index_w-1:0] idx, input logic [tag_w-1:0] tag);
        logic [dmem_pkg::word_w-3:0] waddr;
        for (int i = 0; i < 4; i++) begin
            waddr = {tag, idx, 2'(i)};
            line_m[{idx, 2'(i)}] = mem_m[waddr[mem_aw-1:0]];
        end
        tag_m[idx] = tag;
        val_m[idx] = 1'b1;
    endtask

    // updates the models and sets up what the next completion must show
    task automatic predict(input logic is_store, input logic [31:0] a, input logic [31:0] wd,
                           input logic [3:0] strb, input logic is_cacop, input logic [4:0] code);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0] tag;
        logic [1:0] w;
        logic hit;
        idx = a[dmem_pkg::offset_w +: index_w];
        tag = a[31 -: tag_w];
        w = a[3:2];
        hit = val_m[idx] && tag_m[idx] == tag;
        want_exp = '0;
        want_data = '0;
        chk_data = 1'b0;
        fast = 1'b0;
        if (is_cacop) begin
            if (code == dmem_pkg::cacop_idx_wb && val_m[idx] && dirty_m[idx]) begin
                write_back(idx);
            end
            if (code == dmem_pkg::cacop_init || code == dmem_pkg::cacop_idx_wb) begin
                val_m[idx] = 1'b0;
                dirty_m[idx] = 1'b0;
            end
        end else if (a[1:0] != 2'b00) begin
            want_exp = exp_ale;
            fast = 1'b1;
        end else begin
            fast = hit;
            if (!hit) begin
                if (val_m[idx] && dirty_m[idx]) begin
                    write_back(idx);
                end
                val_m[idx] = 1'b0;
                dirty_m[idx] = 1'b0;
                if (a >= 32'(mem_words * 4)) begin
                    want_exp = exp_bus;
                end else begin
                    refill(idx, tag);
                end
            end
            if (want_exp == '0 && is_store) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        line_m[{idx, w}][8*b +: 8] = wd[8*b +: 8];
                    end
                end
                dirty_m[idx] = 1'b1;
            end else if (want_exp == '0) begin
                want_data = line_m[{idx, w}];
                chk_data = 1'b1;
            end
        end
    endtask

    // called at a falling edge, returns at a falling edge after completion
    task automatic issue(input logic is_store, input logic [31:0] a, input logic [31:0] wd,
                         input logic [3:0] strb, input logic is_cacop, input logic [4:0] code);
        predict(is_store, a, wd, strb, is_cacop, code);
        started = 1'b1;
        @(posedge clk);
        valid <= 1'b1;
        op <= is_store;
        addr <= a;
        w_data_cpu <= wd;
        write_type <= strb;
        cacop_en <= is_cacop;
        cacop_code <= code;
        @(posedge clk);
        valid <= 1'b0;
        do @(negedge clk); while (!data_valid);
        @(negedge clk);
    endtask

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fast_due <= 1'b0;
        end else begin
            fast_due <= valid && fast;
        end
    end

    ap_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !started |-> !data_valid && exp == '0)
        else stop_run("data_valid or exp went high before the first request");

    ap_exp: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid |-> exp == want_exp)
        else stop_run($sformatf("Fail exp expected %h actual %h",
            $sampled(want_exp), $sampled(exp)));

    ap_data: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid && chk_data |-> r_data_cpu == want_data)
        else stop_run($sformatf("Fail r_data_cpu expected %h actual %h",
            $sampled(want_data), $sampled(r_data_cpu)));

    // hits and misaligned accesses finish one cycle after the lookup
    ap_fast_gap: assert property (@(posedge clk) disable iff (!arst_n)
        fast_due |-> !data_valid)
        else stop_run("data_valid came too early for a one-cycle access");

    ap_fast_done: assert property (@(posedge clk) disable iff (!arst_n)
        fast_due |=> data_valid)
        else stop_run("data_valid missing one cycle after a one-cycle access");

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] a;
        lfsr = 32'h24df9387;
        arst_n = 1'b0;
        valid = 1'b0;
        op = 1'b0;
        addr = '0;
        w_data_cpu = '0;
        write_type = '0;
        cacop_en = 1'b0;
        cacop_code = '0;
        started = 1'b0;
        fast = 1'b0;
        chk_data = 1'b0;
        want_data = '0;
        want_exp = '0;
        for (int i = 0; i < mem_words; i++) begin
            mem_m[i] = 32'(i * 4);
        end
        val_m = '0;
        dirty_m = '0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);

        r = take_bits(10);
        issue(dmem_pkg::op_load, {20'h0, r[9:0], 2'b00}, '0, '0, 1'b0, '0);

        // 4 tags on 8 indices keep evictions of dirty lines frequent
        for (int n = 0; n < n_random; n++) begin
            r = take_bits(8);
            d = take_bits(32);
            s = take_bits(4);
            a = {20'h0, r[7:6], 3'b000, r[5:3], r[2:1], 2'b00};
            issue(r[0], a, d, s[3:0], 1'b0, '0);
        end

        issue(dmem_pkg::op_store, 32'h0000_0420, 32'hcafe_0420, 4'hf, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_0420, '0, '0, 1'b1, dmem_pkg::cacop_idx_wb);
        issue(dmem_pkg::op_load, 32'h0000_0420, '0, '0, 1'b0, '0);
        issue(dmem_pkg::op_store, 32'h0000_0844, 32'hbeef_0844, 4'hf, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_0844, '0, '0, 1'b1, dmem_pkg::cacop_init);
        issue(dmem_pkg::op_load, 32'h0000_0844, '0, '0, 1'b0, '0);

        issue(dmem_pkg::op_load, 32'h0000_0102, '0, '0, 1'b0, '0);
        issue(dmem_pkg::op_store, 32'h0000_0421, 32'h1234_5678, 4'hf, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_0420, '0, '0, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_1000, '0, '0, 1'b0, '0);
        issue(dmem_pkg::op_store, 32'h0000_2234, 32'h5555_aaaa, 4'h3, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_0100, '0, '0, 1'b0, '0);
        issue(dmem_pkg::op_load, 32'h0000_0000, '0, '0, 1'b0, '0);

        repeat (2) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: list.f
rtl/dmem_pkg.sv
rtl/axi_rd_if.sv
rtl/axi_wr_if.sv
rtl/dcache.sv
rtl/axi_memory.sv
rtl/data_mem.sv
dv/tb_data_mem.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status carries pass or fail
verilator --binary --timing --assert -j 0 --top-module tb_data_mem -f list.f -o sim_data_mem \
    && ./obj_dir/sim_data_mem \
    || exit 1
